//--- common/rename_pkg.sv
package rename_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Register and tag geometry
	////////////////////////////////////////////////////////////////////////////

	// Architectural register file size
	localparam int N_ARCH_REGS = 32;
	localparam int ARCH_BITS   = 5;
	// Up to 64 physical registers
	localparam int PHYS_BITS   = 6;
	// Up to 16 ROB entries
	localparam int TAG_BITS    = 4;

	typedef logic [ARCH_BITS-1:0] arch_reg_t;
	typedef logic [PHYS_BITS-1:0] phys_reg_t;
	typedef logic [TAG_BITS-1:0]  rob_tag_t;

	////////////////////////////////////////////////////////////////////////////
	// Packets between producer, rename core and execution side
	////////////////////////////////////////////////////////////////////////////

	// Instruction from the producer, architectural names only
	typedef struct packed {
		logic      valid;
		arch_reg_t rd;
		arch_reg_t rs1;
		arch_reg_t rs2;
	} dispatch_t;

	// Renamed instruction, one cycle after dispatch
	typedef struct packed {
		logic      valid;
		phys_reg_t prs1;
		phys_reg_t prs2;
		phys_reg_t prd;
		// Previous mapping of rd, freed at retire
		phys_reg_t old_prd;
		rob_tag_t  tag;
	} renamed_t;

	// Completion report by ROB tag
	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
	} complete_t;

	// In-order retire report
	typedef struct packed {
		logic      valid;
		arch_reg_t rd;
		phys_reg_t prd;
		phys_reg_t old_prd;
	} retire_t;

	// One ROB slot
	typedef struct packed {
		arch_reg_t rd;
		phys_reg_t prd;
		phys_reg_t old_prd;
		logic      done;
	} rob_entry_t;

	// Control FSM, one settle cycle after reset
	typedef enum logic {
		RESET_INIT,
		RUN
	} ctrl_state_t;

endpackage

//--- rename/map_table.sv
`timescale 1ns/10ps

module map_table (
	input  logic                  clock,
	input  logic                  arst_n,
	// Read addresses
	input  rename_pkg::arch_reg_t rd_rs1,
	input  rename_pkg::arch_reg_t rd_rs2,
	input  rename_pkg::arch_reg_t rd_rd,
	// Write port
	input  logic                  we,
	input  rename_pkg::arch_reg_t wr_rd,
	input  rename_pkg::phys_reg_t wr_prd,
	// Read data
	output rename_pkg::phys_reg_t prs1,
	output rename_pkg::phys_reg_t prs2,
	output rename_pkg::phys_reg_t old_prd
);
	import rename_pkg::*;

	// Current physical name of each architectural register
	phys_reg_t map_q [N_ARCH_REGS];

	// Identity mapping out of reset
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < N_ARCH_REGS; i++) begin
				map_q[i] <= phys_reg_t'(i);
			end
		end else if (we) begin
			map_q[wr_rd] <= wr_prd;
		end
	end

	// Combinational reads see the map before this cycle's write
	assign prs1    = map_q[rd_rs1];
	assign prs2    = map_q[rd_rs2];
	// Mapping about to be replaced
	assign old_prd = map_q[rd_rd];

endmodule

//--- rename/free_list.sv
`timescale 1ns/10ps

module free_list #(
	parameter int ROB_DEPTH = 16
) (
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic                  pop,
	input  logic                  push,
	input  rename_pkg::phys_reg_t push_prd,
	// Next register to hand out
	output rename_pkg::phys_reg_t head_prd
);
	import rename_pkg::*;

	localparam int N_PHYS_REGS = N_ARCH_REGS + ROB_DEPTH;
	localparam int PTR_BITS    = $clog2(ROB_DEPTH);

	phys_reg_t           slots [ROB_DEPTH];
	logic [PTR_BITS-1:0] head;
	logic [PTR_BITS-1:0] tail;

	// Pointer step, wraps at the depth
	function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(ROB_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// Starts full with every register above the architectural range
	// Head equals tail both when full and when empty
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int p = N_ARCH_REGS; p < N_PHYS_REGS; p++) begin
				slots[p - N_ARCH_REGS] <= phys_reg_t'(p);
			end
			head <= '0;
			tail <= '0;
		end else begin
			// Allocation side
			if (pop) begin
				head <= next_ptr(head);
			end
			// Retire side returns old mappings
			if (push) begin
				slots[tail] <= push_prd;
				tail        <= next_ptr(tail);
			end
		end
	end

	assign head_prd = slots[head];

endmodule

//--- rename/reorder_buffer.sv
`timescale 1ns/10ps

module reorder_buffer #(
	parameter int ROB_DEPTH = 16
) (
	input  logic                   clock,
	input  logic                   arst_n,
	// Allocation at the tail
	input  logic                   alloc,
	input  rename_pkg::rob_entry_t alloc_entry,
	// Completion by tag, any order
	input  rename_pkg::complete_t  complete,
	// Retire of the head
	input  logic                   retire,
	output rename_pkg::rob_tag_t   tail_tag,
	output logic                   head_ready,
	output rename_pkg::rob_entry_t head_entry
);
	import rename_pkg::*;

	rob_entry_t           entries [ROB_DEPTH];
	// Slot holds a live instruction
	logic [ROB_DEPTH-1:0] occupied;
	rob_tag_t             head;
	rob_tag_t             tail;

	// Tag step, wraps at the depth
	function automatic rob_tag_t next_tag(input rob_tag_t ptr);
		if (ptr == rob_tag_t'(ROB_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Pointers and occupancy
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			occupied <= '0;
			head     <= '0;
			tail     <= '0;
		end else begin
			if (alloc) begin
				occupied[tail] <= 1'b1;
				tail           <= next_tag(tail);
			end
			if (retire) begin
				occupied[head] <= 1'b0;
				head           <= next_tag(head);
			end
		end
	end

	// Entry payload, qualified by occupied
	always_ff @(posedge clock) begin
		if (alloc) begin
			// New entry starts not done
			entries[tail] <= '{rd: alloc_entry.rd, prd: alloc_entry.prd,
				old_prd: alloc_entry.old_prd, done: 1'b0};
		end
		if (complete.valid) begin
			entries[complete.tag].done <= 1'b1;
		end
	end

	assign tail_tag   = tail;
	assign head_entry = entries[head];
	// Oldest instruction present and finished
	assign head_ready = occupied[head] && entries[head].done;

endmodule

//--- rename/rename_ctrl.sv
`timescale 1ns/10ps

module rename_ctrl #(
	parameter int ROB_DEPTH = 16
) (
	input  logic                   clock,
	input  logic                   arst_n,
	// Producer and execution side
	input  rename_pkg::dispatch_t  dispatch_in,
	input  rename_pkg::complete_t  complete_in,
	// Map table read data
	input  rename_pkg::phys_reg_t  map_prs1,
	input  rename_pkg::phys_reg_t  map_prs2,
	input  rename_pkg::phys_reg_t  map_old,
	// Free list and ROB status
	input  rename_pkg::phys_reg_t  free_head,
	input  rename_pkg::rob_tag_t   rob_tail,
	input  logic                   head_ready,
	input  rename_pkg::rob_entry_t head_entry,
	// Map table write
	output logic                   map_we,
	output rename_pkg::arch_reg_t  map_wr_rd,
	output rename_pkg::phys_reg_t  map_wr_prd,
	// Free list control
	output logic                   free_pop,
	output logic                   free_push,
	output rename_pkg::phys_reg_t  free_push_prd,
	// ROB control
	output logic                   rob_alloc,
	output rename_pkg::rob_entry_t rob_alloc_entry,
	output rename_pkg::complete_t  rob_complete,
	output logic                   rob_retire,
	// Registered outputs
	output rename_pkg::renamed_t   renamed_out,
	output rename_pkg::retire_t    retire_out,
	output logic                   credit_return
);
	import rename_pkg::*;

	ctrl_state_t state;
	// Dispatch accepted this cycle
	logic        disp_go;

	// Hold off dispatch for one cycle while the datapath settles
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= RESET_INIT;
		end else begin
			case (state)
				RESET_INIT: state <= RUN;
				RUN:        state <= RUN;
				default:    state <= RESET_INIT;
			endcase
		end
	end

	assign disp_go = (state == RUN) && dispatch_in.valid;

	////////////////////////////////////////////////////////////////////////////
	// Dispatch side
	////////////////////////////////////////////////////////////////////////////

	// New mapping for rd takes the free list head
	assign map_we     = disp_go;
	assign map_wr_rd  = dispatch_in.rd;
	assign map_wr_prd = free_head;
	assign free_pop   = disp_go;
	assign rob_alloc  = disp_go;

	always_comb begin
		rob_alloc_entry = '{rd: dispatch_in.rd, prd: free_head, old_prd: map_old, done: 1'b0};
	end

	// Completions go straight to the ROB
	assign rob_complete = complete_in;

	////////////////////////////////////////////////////////////////////////////
	// Retire side
	////////////////////////////////////////////////////////////////////////////

	// Retire the head once done and recycle its old mapping
	assign rob_retire    = head_ready;
	assign free_push     = head_ready;
	assign free_push_prd = head_entry.old_prd;

	// Output registers lag the acting edge by one cycle
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			renamed_out   <= '0;
			retire_out    <= '0;
			credit_return <= 1'b0;
		end else begin
			renamed_out   <= '{valid: disp_go, prs1: map_prs1, prs2: map_prs2,
				prd: free_head, old_prd: map_old, tag: rob_tail};
			retire_out    <= '{valid: head_ready, rd: head_entry.rd,
				prd: head_entry.prd, old_prd: head_entry.old_prd};
			// One credit per retired entry
			credit_return <= head_ready;
		end
	end

endmodule

//--- source/rename_unit.sv
`timescale 1ns/10ps

module rename_unit #(
	parameter int ROB_DEPTH = 16
) (
	input  logic                  clock,
	input  logic                  arst_n,
	input  rename_pkg::dispatch_t dispatch_in,
	input  rename_pkg::complete_t complete_in,
	output rename_pkg::renamed_t  renamed_out,
	output rename_pkg::retire_t   retire_out,
	output logic                  credit_return
);
	import rename_pkg::*;

	// Map table
	logic       map_we;
	arch_reg_t  map_wr_rd;
	phys_reg_t  map_wr_prd;
	phys_reg_t  map_prs1;
	phys_reg_t  map_prs2;
	phys_reg_t  map_old;
	// Free list
	logic       free_pop;
	logic       free_push;
	phys_reg_t  free_push_prd;
	phys_reg_t  free_head;
	// ROB
	logic       rob_alloc;
	rob_entry_t rob_alloc_entry;
	complete_t  rob_complete;
	logic       rob_retire;
	rob_tag_t   rob_tail;
	logic       head_ready;
	rob_entry_t head_entry;

	////////////////////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////////////////////

	rename_ctrl #(
		.ROB_DEPTH(ROB_DEPTH)
	) i_rename_ctrl (
		.clock          (clock),
		.arst_n         (arst_n),
		.dispatch_in    (dispatch_in),
		.complete_in    (complete_in),
		.map_prs1       (map_prs1),
		.map_prs2       (map_prs2),
		.map_old        (map_old),
		.free_head      (free_head),
		.rob_tail       (rob_tail),
		.head_ready     (head_ready),
		.head_entry     (head_entry),
		.map_we         (map_we),
		.map_wr_rd      (map_wr_rd),
		.map_wr_prd     (map_wr_prd),
		.free_pop       (free_pop),
		.free_push      (free_push),
		.free_push_prd  (free_push_prd),
		.rob_alloc      (rob_alloc),
		.rob_alloc_entry(rob_alloc_entry),
		.rob_complete   (rob_complete),
		.rob_retire     (rob_retire),
		.renamed_out    (renamed_out),
		.retire_out     (retire_out),
		.credit_return  (credit_return)
	);

	////////////////////////////////////////////////////////////////////////////
	// Datapath blocks
	////////////////////////////////////////////////////////////////////////////

	// Sources and rd looked up straight from the incoming packet
	map_table i_map_table (
		.clock  (clock),
		.arst_n (arst_n),
		.rd_rs1 (dispatch_in.rs1),
		.rd_rs2 (dispatch_in.rs2),
		.rd_rd  (dispatch_in.rd),
		.we     (map_we),
		.wr_rd  (map_wr_rd),
		.wr_prd (map_wr_prd),
		.prs1   (map_prs1),
		.prs2   (map_prs2),
		.old_prd(map_old)
	);

	free_list #(
		.ROB_DEPTH(ROB_DEPTH)
	) i_free_list (
		.clock   (clock),
		.arst_n  (arst_n),
		.pop     (free_pop),
		.push    (free_push),
		.push_prd(free_push_prd),
		.head_prd(free_head)
	);

	reorder_buffer #(
		.ROB_DEPTH(ROB_DEPTH)
	) i_reorder_buffer (
		.clock      (clock),
		.arst_n     (arst_n),
		.alloc      (rob_alloc),
		.alloc_entry(rob_alloc_entry),
		.complete   (rob_complete),
		.retire     (rob_retire),
		.tail_tag   (rob_tail),
		.head_ready (head_ready),
		.head_entry (head_entry)
	);

endmodule

//--- bench/rename_model.svh
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Reference rename state, updated once per modeled clock edge
////////////////////////////////////////////////////////////////////////////

// Current arch to phys mapping
phys_reg_t  ref_map [N_ARCH_REGS];
// Free registers in hand-out order
phys_reg_t  ref_free [$];
// In-flight instructions, oldest first, with their tags alongside
rob_entry_t ref_rob [$];
rob_tag_t   ref_tags [$];
rob_tag_t   ref_tail;

// Identity map, free list from the first register past the arch range
function automatic void reset_model(input int depth);
	for (int i = 0; i < N_ARCH_REGS; i++) begin
		ref_map[i] = phys_reg_t'(i);
	end
	ref_free.delete();
	for (int p = N_ARCH_REGS; p < N_ARCH_REGS + depth; p++) begin
		ref_free.push_back(phys_reg_t'(p));
	end
	ref_rob.delete();
	ref_tags.delete();
	ref_tail = '0;
endfunction

// Sources read the map before rd is remapped
function automatic renamed_t rename_one(input dispatch_t d, input int depth);
	renamed_t   r;
	rob_entry_t e;
	r.valid   = 1'b1;
	r.prs1    = ref_map[d.rs1];
	r.prs2    = ref_map[d.rs2];
	r.old_prd = ref_map[d.rd];
	r.prd     = ref_free.pop_front();
	r.tag     = ref_tail;
	ref_map[d.rd] = r.prd;
	e.rd      = d.rd;
	e.prd     = r.prd;
	e.old_prd = r.old_prd;
	e.done    = 1'b0;
	ref_rob.push_back(e);
	ref_tags.push_back(ref_tail);
	// Tag wraps at the ROB depth
	ref_tail = (ref_tail == rob_tag_t'(depth - 1)) ? '0 : ref_tail + 1'b1;
	return r;
endfunction

// Oldest entry leaves only once done, old mapping goes back to the free list
function automatic retire_t retire_head();
	retire_t r;
	r = '0;
	if (ref_rob.size() > 0 && ref_rob[0].done) begin
		r.valid   = 1'b1;
		r.rd      = ref_rob[0].rd;
		r.prd     = ref_rob[0].prd;
		r.old_prd = ref_rob[0].old_prd;
		ref_free.push_back(ref_rob[0].old_prd);
		void'(ref_rob.pop_front());
		void'(ref_tags.pop_front());
	end
	return r;
endfunction

function automatic void mark_done(input rob_tag_t tag);
	foreach (ref_tags[i]) begin
		if (ref_tags[i] == tag) begin
			ref_rob[i].done = 1'b1;
		end
	end
endfunction

`endif

//--- bench/tb_rename_unit.sv
`timescale 1ns/10ps

module tb_rename_unit;
	import rename_pkg::*;

	localparam int ROB_DEPTH  = 16;
	localparam int N_DISPATCH = 600;
	// Cycle limit for each wait loop
	localparam int TIMEOUT    = 20000;

	logic      clock;
	logic      arst_n;
	dispatch_t dispatch_in;
	complete_t complete_in;
	renamed_t  renamed_out;
	retire_t   retire_out;
	logic      credit_return;

	int        seed = 54586;
	// Producer side credit counter
	int        credits;
	int        sent;
	int        cycles;
	// Expected outputs of the edge just driven
	renamed_t  exp_renamed;
	retire_t   exp_retire;

	`include "rename_model.svh"

	rename_unit #(
		.ROB_DEPTH(ROB_DEPTH)
	) i_rename_unit (
		.clock        (clock),
		.arst_n       (arst_n),
		.dispatch_in  (dispatch_in),
		.complete_in  (complete_in),
		.renamed_out  (renamed_out),
		.retire_out   (retire_out),
		.credit_return(credit_return)
	);

	// 8 ns period
	always #4 clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// Checking
	////////////////////////////////////////////////////////////////////////////

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation stopped on error");
	endtask

	// Payload only matters when valid is expected
	task automatic compare_renamed(input renamed_t exp, input renamed_t act);
		if (exp.valid ? (act !== exp) : (act.valid !== 1'b0)) begin
			fail_run($sformatf("FAIL at %0d ns: renamed_out expected %h got %h",
				$time, exp, act));
		end
	endtask

	task automatic compare_retire(input retire_t exp, input retire_t act);
		if (exp.valid ? (act !== exp) : (act.valid !== 1'b0)) begin
			fail_run($sformatf("FAIL at %0d ns: retire_out expected %h got %h",
				$time, exp, act));
		end
	endtask

	task automatic compare_credit(input logic exp, input logic act);
		if (act !== exp) begin
			fail_run($sformatf("FAIL at %0d ns: credit_return expected %b got %b",
				$time, exp, act));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	function automatic int rand_below(input int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	// Random tag among in-flight entries not yet completed
	function automatic complete_t pick_completion();
		complete_t c;
		int        open_idx [$];
		c = '0;
		foreach (ref_rob[i]) begin
			if (!ref_rob[i].done) begin
				open_idx.push_back(i);
			end
		end
		if (open_idx.size() > 0) begin
			c.valid = 1'b1;
			c.tag   = ref_tags[open_idx[rand_below(open_idx.size())]];
		end
		return c;
	endfunction

	// Check the last edge on the falling edge and then drive and model the next one
	task automatic step(input int disp_pct, input int done_pct);
		dispatch_t d;
		complete_t c;
		@(negedge clock);
		compare_renamed(exp_renamed, renamed_out);
		compare_retire(exp_retire, retire_out);
		compare_credit(exp_retire.valid, credit_return);
		if (credit_return) begin
			credits++;
		end
		d = '0;
		c = '0;
		if (rand_below(100) < done_pct) begin
			c = pick_completion();
		end
		// Dispatch only while holding a credit
		if (credits > 0 && rand_below(100) < disp_pct) begin
			d.valid = 1'b1;
			d.rd    = arch_reg_t'($random(seed));
			d.rs1   = arch_reg_t'($random(seed));
			d.rs2   = arch_reg_t'($random(seed));
		end
		// Retire uses done bits from earlier edges only
		exp_retire = retire_head();
		exp_renamed = '0;
		if (d.valid) begin
			exp_renamed = rename_one(d, ROB_DEPTH);
			credits--;
			sent++;
		end
		if (c.valid) begin
			mark_done(c.tag);
		end
		dispatch_in = d;
		complete_in = c;
	endtask

	initial begin
		clock       = 1'b0;
		arst_n      = 1'b0;
		dispatch_in = '0;
		complete_in = '0;
		credits     = ROB_DEPTH;
		sent        = 0;
		exp_renamed = '0;
		exp_retire  = '0;
		reset_model(ROB_DEPTH);
		repeat (2) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;
		// Idle through the control settle cycle
		step(0, 0);
		step(0, 0);
		// Back to back until the credits run out, then stall
		for (int i = 0; i < 40; i++) begin
			step(100, 0);
		end
		cycles = 0;
		while (sent < N_DISPATCH && cycles < TIMEOUT) begin
			step(70, 60);
			cycles++;
		end
		if (sent < N_DISPATCH) begin
			fail_run("Timeout: producer could not finish its dispatches");
		end
		// Drain until every credit has come back
		cycles = 0;
		while ((credits != ROB_DEPTH || ref_rob.size() != 0) && cycles < TIMEOUT) begin
			step(0, 80);
			cycles++;
		end
		if (credits != ROB_DEPTH) begin
			fail_run("Timeout: not all credits returned after the final completions");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

//--- tb.f
+incdir+bench
common/rename_pkg.sv
rename/map_table.sv
rename/free_list.sv
rename/reorder_buffer.sv
rename/rename_ctrl.sv
source/rename_unit.sv
bench/tb_rename_unit.sv

//--- run.sh
#!/bin/sh
# Build and run the rename unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_rename_unit -o sim_tb

# Simulator status is not trusted, the log decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log || ! grep -q "Test completed successfully" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi
echo "Simulation PASSED"
